//--- src/soc_bus_pkg.sv
// Bus package: request and response types, address view and peripheral slot map
package soc_bus_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int SLOT_W    = 4;
    localparam int OFFSET_W  = 12;
    localparam int REQ_DEPTH = 2;  // Queue entries, also credits after reset

    // Peripheral slots, same numbering as the SoC APB decoder
    localparam logic [SLOT_W-1:0] SLOT_GPIO  = 4'd1;
    localparam logic [SLOT_W-1:0] SLOT_TIMER = 4'd3;

    typedef struct packed {
        logic [ADDR_W-SLOT_W-OFFSET_W-1:0] unused;
        logic [SLOT_W-1:0]                 slot;
        logic [OFFSET_W-1:0]               offset;
    } bus_addr_fields_t;

    // Raw word for the queue, decoded fields for the bridge
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        bus_addr_fields_t  f;
    } bus_addr_u;

    typedef struct packed {
        logic              write;
        bus_addr_u         addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              err;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // Shared peripheral bus, selects travel separately
    typedef struct packed {
        logic                enable;
        logic                write;
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]   wdata;
    } periph_bus_t;

endpackage

//--- src/periph_pkg.sv
// Peripheral package: register map and field sizes of the GPIO and timer blocks
package periph_pkg;

    localparam int GPIO_N = 16;  // Pins
    localparam int TMR_N  = 2;   // Compare channels
    localparam int IRQ_N  = 3;   // GPIO, timer A, timer B

    //////////////////////////////
    // GPIO registers
    //////////////////////////////
    localparam logic [11:0] GPIO_DIR      = 12'h000;
    localparam logic [11:0] GPIO_OUT      = 12'h004;
    localparam logic [11:0] GPIO_IN       = 12'h008;
    localparam logic [11:0] GPIO_INT_EN   = 12'h00C;
    localparam logic [11:0] GPIO_INT_STAT = 12'h010;  // Write 1 to clear

    //////////////////////////////
    // Timer registers
    //////////////////////////////
    localparam logic [11:0] TMR_CTRL  = 12'h000;  // Bit 0 enables A, bit 1 enables B
    localparam logic [11:0] TMR_A_CMP = 12'h004;
    localparam logic [11:0] TMR_B_CMP = 12'h008;
    localparam logic [11:0] TMR_A_CNT = 12'h00C;
    localparam logic [11:0] TMR_B_CNT = 12'h010;
    localparam logic [11:0] TMR_STAT  = 12'h014;  // Bit 0 A, bit 1 B

endpackage

//--- src/req_queue.sv
// Request queue: credited circular FIFO in front of the APB bridge
`timescale 1ns/1ps

module req_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  soc_bus_pkg::bus_req_t req,
    input  logic                  head_take,
    output logic                  head_valid,
    output soc_bus_pkg::bus_req_t head,
    output logic                  credit_return
);
    import soc_bus_pkg::*;

    bus_req_t                           mem [REQ_DEPTH];
    logic [$clog2(REQ_DEPTH)-1:0]       wr_ptr, rd_ptr;
    logic [$clog2(REQ_DEPTH+1)-1:0]     count;
    logic                               pop;

    assign head_valid    = (count != '0);
    assign head          = mem[rd_ptr];
    assign pop           = head_take && head_valid;
    assign credit_return = pop;  // One credit back per entry handed on

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == REQ_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == REQ_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

//--- src/apb_bridge.sv
// APB bridge: setup and access sequencing, slot decode and response capture
`timescale 1ns/1ps

module apb_bridge (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             head_valid,
    input  soc_bus_pkg::bus_req_t            head,
    output logic                             head_take,
    output soc_bus_pkg::periph_bus_t         pbus,
    output logic                             gpio_sel,
    output logic                             timer_sel,
    input  logic [soc_bus_pkg::DATA_W-1:0]   gpio_rdata,
    input  logic [soc_bus_pkg::DATA_W-1:0]   timer_rdata,
    output logic                             rsp_valid,
    output soc_bus_pkg::bus_rsp_t            rsp
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_t;

    state_t   state;
    bus_req_t cur;  // Transfer in flight
    logic     gpio_hit, timer_hit;
    logic     busy;

    // Next setup may overlap the response cycle
    assign head_take = head_valid && (state == ST_IDLE || state == ST_ACCESS);

    assign gpio_hit  = (cur.addr.f.slot == SLOT_GPIO);
    assign timer_hit = (cur.addr.f.slot == SLOT_TIMER);
    assign busy      = (state != ST_IDLE);

    assign gpio_sel  = busy && gpio_hit;
    assign timer_sel = busy && timer_hit;  // No select for an empty slot

    assign pbus.enable = (state == ST_ACCESS);
    assign pbus.write  = cur.write;
    assign pbus.offset = cur.addr.f.offset;
    assign pbus.wdata  = cur.wdata;

    always_ff @(posedge clk) begin
        if (head_take) begin
            cur <= head;
        end
    end

    //////////////////////////////
    // Phase sequencer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (head_take) begin
            state <= ST_SETUP;
        end else if (state == ST_SETUP) begin
            state <= ST_ACCESS;
        end else begin
            state <= ST_IDLE;
        end
    end

    //////////////////////////////
    // Response capture
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (state == ST_ACCESS);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_ACCESS) begin
            rsp.err <= !(gpio_hit || timer_hit);
            if (cur.write) begin
                rsp.rdata <= '0;
            end else if (gpio_hit) begin
                rsp.rdata <= gpio_rdata;
            end else if (timer_hit) begin
                rsp.rdata <= timer_rdata;
            end else begin
                rsp.rdata <= '0;  // Unmapped slot
            end
        end
    end

endmodule

//--- src/apb_gpio.sv
// GPIO block: direction, output, synchronized input and rising-edge interrupts
`timescale 1ns/1ps

module apb_gpio (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           sel,
    input  soc_bus_pkg::periph_bus_t       pbus,
    output logic [soc_bus_pkg::DATA_W-1:0] rdata,
    input  logic [periph_pkg::GPIO_N-1:0]  gpio_in,
    output logic [periph_pkg::GPIO_N-1:0]  gpio_out,
    output logic [periph_pkg::GPIO_N-1:0]  gpio_oe,
    output logic                           irq
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    logic [GPIO_N-1:0] dir_q, out_q, int_en_q, stat_q;
    logic [GPIO_N-1:0] sync1_q, sync2_q, prev_q;
    logic [GPIO_N-1:0] rise, stat_clr;
    logic              wr_en;

    assign wr_en    = sel && pbus.enable && pbus.write;
    assign rise     = sync2_q & ~prev_q & int_en_q;  // Enabled pins only
    assign stat_clr = (wr_en && pbus.offset == GPIO_INT_STAT) ? pbus.wdata[GPIO_N-1:0] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            dir_q    <= '0;
            out_q    <= '0;
            int_en_q <= '0;
            stat_q   <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
        end else begin
            sync1_q <= gpio_in;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;                    // Edge reference
            stat_q  <= (stat_q & ~stat_clr) | rise; // New edge beats clear
            if (wr_en) begin
                case (pbus.offset)
                    GPIO_DIR:    dir_q    <= pbus.wdata[GPIO_N-1:0];
                    GPIO_OUT:    out_q    <= pbus.wdata[GPIO_N-1:0];
                    GPIO_INT_EN: int_en_q <= pbus.wdata[GPIO_N-1:0];
                    default:     ;
                endcase
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (pbus.offset)
            GPIO_DIR:      rdata[GPIO_N-1:0] = dir_q;
            GPIO_OUT:      rdata[GPIO_N-1:0] = out_q;
            GPIO_IN:       rdata[GPIO_N-1:0] = sync2_q;
            GPIO_INT_EN:   rdata[GPIO_N-1:0] = int_en_q;
            GPIO_INT_STAT: rdata[GPIO_N-1:0] = stat_q;
            default:       rdata = '0;
        endcase
    end

    assign gpio_out = out_q;
    assign gpio_oe  = dir_q;
    assign irq      = |stat_q;

endmodule

//--- src/apb_timer.sv
// Compare timer: two free-running channels with sticky match flags
`timescale 1ns/1ps

module apb_timer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           sel,
    input  soc_bus_pkg::periph_bus_t       pbus,
    output logic [soc_bus_pkg::DATA_W-1:0] rdata,
    output logic [periph_pkg::TMR_N-1:0]   irq
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    logic [TMR_N-1:0]  ctrl_q, stat_q;
    logic [DATA_W-1:0] cnt_q [TMR_N];
    logic [DATA_W-1:0] cmp_q [TMR_N];
    logic [TMR_N-1:0]  hit, stat_clr;
    logic              wr_en;

    assign wr_en    = sel && pbus.enable && pbus.write;
    assign stat_clr = (wr_en && pbus.offset == TMR_STAT) ? pbus.wdata[TMR_N-1:0] : '0;

    always_comb begin
        for (int ch = 0; ch < TMR_N; ch++) begin
            hit[ch] = ctrl_q[ch] && (cnt_q[ch] == cmp_q[ch]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
            stat_q <= '0;
            for (int ch = 0; ch < TMR_N; ch++) begin
                cnt_q[ch] <= '0;
                cmp_q[ch] <= '0;
            end
        end else begin
            for (int ch = 0; ch < TMR_N; ch++) begin
                if (hit[ch]) begin
                    cnt_q[ch] <= '0;  // Wrap on match
                end else if (ctrl_q[ch]) begin
                    cnt_q[ch] <= cnt_q[ch] + 1'b1;
                end
            end
            stat_q <= (stat_q & ~stat_clr) | hit;
            if (wr_en) begin
                case (pbus.offset)  // Bus write wins over counting
                    TMR_CTRL:  ctrl_q   <= pbus.wdata[TMR_N-1:0];
                    TMR_A_CMP: cmp_q[0] <= pbus.wdata;
                    TMR_B_CMP: cmp_q[1] <= pbus.wdata;
                    TMR_A_CNT: cnt_q[0] <= pbus.wdata;
                    TMR_B_CNT: cnt_q[1] <= pbus.wdata;
                    default:   ;
                endcase
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (pbus.offset)
            TMR_CTRL:  rdata[TMR_N-1:0] = ctrl_q;
            TMR_A_CMP: rdata = cmp_q[0];
            TMR_B_CMP: rdata = cmp_q[1];
            TMR_A_CNT: rdata = cnt_q[0];
            TMR_B_CNT: rdata = cnt_q[1];
            TMR_STAT:  rdata[TMR_N-1:0] = stat_q;
            default:   rdata = '0;
        endcase
    end

    assign irq = stat_q;

endmodule

//--- src/periph_subsys.sv
// Peripheral subsystem top: request queue, APB bridge, GPIO and compare timer
`timescale 1ns/1ps

module periph_subsys (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  soc_bus_pkg::bus_req_t         req,
    output logic                          credit_return,
    output logic                          rsp_valid,
    output soc_bus_pkg::bus_rsp_t         rsp,
    input  logic [periph_pkg::GPIO_N-1:0] gpio_in,
    output logic [periph_pkg::GPIO_N-1:0] gpio_out,
    output logic [periph_pkg::GPIO_N-1:0] gpio_oe,
    output logic [periph_pkg::IRQ_N-1:0]  irq
);
    import soc_bus_pkg::*;
    import periph_pkg::*;

    logic              head_valid;
    bus_req_t          head;
    logic              head_take;
    periph_bus_t       pbus;
    logic              gpio_sel, timer_sel;
    logic [DATA_W-1:0] gpio_rdata, timer_rdata;
    logic              gpio_irq;
    logic [TMR_N-1:0]  timer_irq;

    req_queue i_req_queue (
        .clk, .reset, .req_valid, .req, .head_take,
        .head_valid, .head, .credit_return
    );

    apb_bridge i_apb_bridge (
        .clk, .reset, .head_valid, .head, .head_take, .pbus,
        .gpio_sel, .timer_sel, .gpio_rdata, .timer_rdata, .rsp_valid, .rsp
    );

    apb_gpio i_apb_gpio (
        .clk, .reset, .sel(gpio_sel), .pbus, .rdata(gpio_rdata),
        .gpio_in, .gpio_out, .gpio_oe, .irq(gpio_irq)
    );

    apb_timer i_apb_timer (
        .clk, .reset, .sel(timer_sel), .pbus, .rdata(timer_rdata), .irq(timer_irq)
    );

    assign irq = {timer_irq, gpio_irq};  // GPIO lowest, timer B on top

endmodule

//--- tb/tb_clock_gen.sv
// Testbench clock source with a 40 ns period
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;  // Half period
        end
    end

endmodule

//--- tb/tb_periph_subsys.sv
// Testbench top that replays the stimulus file into the peripheral subsystem and checks responses
`timescale 1ns/1ps

module tb_periph_subsys;
    import soc_bus_pkg::*;
    import periph_pkg::*;

    localparam int MAX_OPS = 64;
    localparam int N_COL   = 5;    // op, addr, data, expected, flags
    localparam int TIMEOUT = 200;  // Cycles allowed per wait

    logic              clk;
    logic              reset;
    logic              req_valid;
    bus_req_t          req;
    logic              credit_return;
    logic              rsp_valid;
    bus_rsp_t          rsp;
    logic [GPIO_N-1:0] gpio_in, gpio_out, gpio_oe;
    logic [IRQ_N-1:0]  irq;

    logic [31:0] stim [0:MAX_OPS*N_COL-1];
    logic [31:0] exp_data_q [$];
    logic        exp_err_q [$];
    logic        exp_bound_q [$];  // Read data only has an upper bound
    int          credits;
    int          n_req, n_credit, n_stall;

    tb_clock_gen i_clk_gen (.clk);

    periph_subsys i_dut (
        .clk, .reset, .req_valid, .req, .credit_return, .rsp_valid, .rsp,
        .gpio_in, .gpio_out, .gpio_oe, .irq
    );

    //////////////////////////////
    // Checking helpers
    //////////////////////////////
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic report_failure(input string reason);
        $display("ERROR: %s", reason);
        $display("=== FAIL ===");
        $fatal(1, "%s", reason);
    endtask

    // Sample at the falling edge, settle credits and match responses in order
    task automatic tick();
        logic [31:0] exp_data;
        logic        exp_err;
        logic        exp_bound;
        @(negedge clk);
        if (credit_return) begin
            credits++;
            n_credit++;
            if (credits > REQ_DEPTH) begin
                report_failure("more credits returned than were spent");
            end
        end
        if (rsp_valid) begin
            if (exp_data_q.size() == 0) begin
                report_failure("response arrived with no request outstanding");
            end
            exp_data  = exp_data_q.pop_front();
            exp_err   = exp_err_q.pop_front();
            exp_bound = exp_bound_q.pop_front();
            check("rsp.err", rsp.err, exp_err);
            if (exp_bound) begin
                check("rsp.rdata within bound", rsp.rdata <= exp_data, 1);
            end else begin
                check("rsp.rdata", rsp.rdata, exp_data);
            end
        end
    endtask

    //////////////////////////////
    // Bus operations
    //////////////////////////////
    task automatic send(input logic write, input logic [31:0] addr, input logic [31:0] data,
                        input logic [31:0] exp_val, input logic err, input logic bound);
        int waited;
        waited = 0;
        while (credits == 0) begin  // Stall until a credit comes back
            if (waited == TIMEOUT) begin
                report_failure("no credit returned before the timeout");
            end
            tick();
            waited++;
        end
        if (waited != 0) begin
            n_stall++;
        end
        req_valid    = 1'b1;
        req.write    = write;
        req.addr.raw = addr;
        req.wdata    = data;
        credits--;
        n_req++;
        exp_data_q.push_back(exp_val);
        exp_err_q.push_back(err);
        exp_bound_q.push_back(bound);
        tick();
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0) begin
            if (waited == TIMEOUT) begin
                report_failure("outstanding response did not arrive before the timeout");
            end
            tick();
            waited++;
        end
    endtask

    task automatic wait_irq(input logic [IRQ_N-1:0] mask, input logic [IRQ_N-1:0] level);
        int waited;
        drain();
        waited = 0;
        while ((irq & mask) !== level) begin
            if (waited == TIMEOUT) begin
                report_failure("interrupt lines did not reach the expected level");
            end
            tick();
            waited++;
        end
    endtask

    //////////////////////////////
    // Replay of the stimulus file
    //////////////////////////////
    initial begin
        int          op_idx;
        logic        done;
        logic [31:0] op, addr, data, exp_val, flags;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        gpio_in   = '0;
        credits   = REQ_DEPTH;  // Full credit after reset
        n_req     = 0;
        n_credit  = 0;
        n_stall   = 0;
        void'($urandom(32'h6d46_b19e));
        $readmemh("tb/periph_input.txt", stim);
        if ($isunknown(stim[0])) begin
            report_failure("stimulus file tb/periph_input.txt could not be read");
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check("credit_return", credit_return, 0);
        check("rsp_valid", rsp_valid, 0);
        check("irq", irq, 0);

        op_idx = 0;
        done   = 1'b0;
        while (!done) begin
            if (op_idx == MAX_OPS) begin
                report_failure("stimulus file has no end marker");
            end
            op      = stim[op_idx*N_COL];
            addr    = stim[op_idx*N_COL+1];
            data    = stim[op_idx*N_COL+2];
            exp_val = stim[op_idx*N_COL+3];
            flags   = stim[op_idx*N_COL+4];
            if (op inside {1, 2, 3} && !flags[1]) begin
                repeat ($urandom_range(3, 0)) begin
                    tick();
                end
            end
            case (op)
                0: done = 1'b1;
                1: send(1'b1, addr, data, exp_val, flags[0], 1'b0);
                2: send(1'b0, addr, 32'h0, exp_val, flags[0], 1'b0);
                3: send(1'b0, addr, 32'h0, exp_val, flags[0], 1'b1);
                4: begin
                    drain();
                    gpio_in = data[GPIO_N-1:0];
                    tick();
                end
                5: wait_irq(data[IRQ_N-1:0], exp_val[IRQ_N-1:0]);
                6: begin
                    drain();
                    check("gpio_out", gpio_out, data);
                    check("gpio_oe", gpio_oe, exp_val);
                end
                7: begin
                    drain();
                    repeat (data) begin
                        tick();
                    end
                end
                default: report_failure("unknown operation code in stimulus file");
            endcase
            op_idx++;
        end

        drain();
        check("credit returns", n_credit, n_req);
        check("credit stalls seen", n_stall != 0, 1);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- tb/periph_input.txt
// op addr data expect flags (hex); ops 1 wr, 2 rd, 3 rd at most expect, 4 set pins,
// 5 wait irq&data==expect, 6 gpio_out/gpio_oe, 7 idle, 0 end; flags bit0 err, bit1 no gap
1 00001000 0000a5f0 00000000 0
1 00001004 00003c3c 00000000 0
6 00000000 00003c3c 0000a5f0 0
2 00001000 00000000 0000a5f0 0
2 00001004 00000000 00003c3c 0
4 00000000 00000081 00000000 0
2 00001008 00000000 00000081 0
2 00001010 00000000 00000000 0
1 0000100c 00000100 00000000 0
4 00000000 00000189 00000000 0
5 00000000 00000001 00000001 0
2 00001010 00000000 00000100 0
1 00001010 00000100 00000000 0
5 00000000 00000001 00000000 0
1 00003004 00000005 00000000 0
1 00003000 00000001 00000000 0
5 00000000 00000002 00000002 0
3 0000300c 00000000 00000005 0
1 00003000 00000000 00000000 0
1 00003014 00000001 00000000 0
5 00000000 00000002 00000000 0
1 00003008 00000003 00000000 0
1 00003000 00000002 00000000 0
5 00000000 00000004 00000004 0
3 00003010 00000000 00000003 0
1 00003000 00000000 00000000 0
1 00003014 00000002 00000000 0
5 00000000 00000006 00000000 0
1 00004004 ffffffff 00000000 1
1 00000000 0000ffff 00000000 1
2 00005004 00000000 00000000 1
6 00000000 00003c3c 0000a5f0 0
2 00001000 00000000 0000a5f0 2
2 00001004 00000000 00003c3c 2
2 00003004 00000000 00000005 2
2 00003008 00000000 00000003 2
2 00001008 00000000 00000189 2
2 00000008 00000000 00000000 3
2 0000100c 00000000 00000100 2
7 00000000 00000008 00000000 0
5 00000000 00000007 00000000 0
0 00000000 00000000 00000000 0

//--- project.f
src/soc_bus_pkg.sv
src/periph_pkg.sv
src/req_queue.sv
src/apb_bridge.sv
src/apb_gpio.sv
src/apb_timer.sv
src/periph_subsys.sv
tb/tb_clock_gen.sv
tb/tb_periph_subsys.sv

//--- Bender.yml
package:
  name: periph_subsys

sources:
  - src/soc_bus_pkg.sv
  - src/periph_pkg.sv
  - src/req_queue.sv
  - src/apb_bridge.sv
  - src/apb_gpio.sv
  - src/apb_timer.sv
  - src/periph_subsys.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_periph_subsys.sv
